/* src/ooo_macros.svh */
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// reorder buffer slots
`define ROB_ENTRY 8

// common data bus ports
`define NUM_FU 2

// architectural and physical register counts
// 14 - 8 leaves 6 free registers at reset
`define NUM_ARCH_REG 8
`define NUM_PHYS_REG 14

// store buffer slots
`define SB_DEPTH 4

// store payload widths
`define ADDR_W 16
`define DATA_W 32

`endif

/* src/ooo_pkg.sv */
`default_nettype none

`include "ooo_macros.svh"

package ooo_pkg;

  // index types
  typedef logic [$clog2(`ROB_ENTRY)-1:0]    rob_idx_t;
  typedef logic [$clog2(`NUM_ARCH_REG)-1:0] arch_reg_t;
  typedef logic [$clog2(`NUM_PHYS_REG)-1:0] phys_reg_t;

  // one writeback port, no data travels with it
  typedef struct packed {
    logic     valid;
    rob_idx_t rob_dest;
  } cdb_t;

  // one reorder buffer slot
  typedef struct packed {
    logic      wb;
    logic      w_v;
    logic      is_store;
    // register given back to the free list at commit
    phys_reg_t freed_reg;
  } rob_entry_t;

  // one store buffer entry
  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
  } store_t;

endpackage

`default_nettype wire

/* src/sync_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t    = logic,
  parameter int  DEPTH        = 4,
  parameter bit  PRELOAD      = 1'b0,
  parameter int  PRELOAD_BASE = 0
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PAY_W = $bits(payload_t);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  // depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign head_o  = mem_q[rd_ptr_q];

  // a pop in the same cycle makes room for a push into a full buffer
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  always_ff @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      // preloaded buffer starts full with consecutive values
      if (PRELOAD)
      begin
        for (int i = 0; i < DEPTH; i++)
        begin
          mem_q[i] <= PAY_W'(PRELOAD_BASE + i);
        end
      end
    end
    else if (do_push)
    begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= PRELOAD ? CNT_W'(DEPTH) : '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop)
      begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (do_push && !do_pop)
      begin
        cnt_q <= cnt_q + 1'b1;
      end
      else if (do_pop && !do_push)
      begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/rename_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ooo_macros.svh"

module rename_dispatch (
  input  logic               clk_i,
  input  logic               reset_i,

  // instruction offered from the front end
  input  logic               dispatch_valid_i,
  input  logic               dispatch_w_v_i,
  input  logic               dispatch_is_store_i,
  input  ooo_pkg::arch_reg_t dispatch_dest_i,
  input  logic [`ADDR_W-1:0] dispatch_addr_i,
  input  logic [`DATA_W-1:0] dispatch_data_i,
  output logic               dispatch_ready_o,

  // free list
  input  ooo_pkg::phys_reg_t fl_head_i,
  input  logic               fl_empty_i,
  output logic               fl_pop_o,

  // store buffer
  input  logic               sb_full_i,
  output logic               sb_push_o,
  output ooo_pkg::store_t    sb_data_o,

  // reorder buffer
  input  logic               rob_ready_i,
  output logic               issue_valid_o,
  output ooo_pkg::rob_entry_t issue_entry_o
);

  import ooo_pkg::*;

  phys_reg_t map_q [`NUM_ARCH_REG];
  logic      fl_ok;
  logic      sb_ok;
  logic      accept;

  // a writer needs a free register, a store needs a buffer slot
  assign fl_ok = !dispatch_w_v_i || !fl_empty_i;
  assign sb_ok = !dispatch_is_store_i || !sb_full_i;

  assign dispatch_ready_o = rob_ready_i && fl_ok && sb_ok;
  assign accept           = dispatch_valid_i && dispatch_ready_o;

  assign fl_pop_o      = accept && dispatch_w_v_i;
  assign sb_push_o     = accept && dispatch_is_store_i;
  assign issue_valid_o = accept;

  assign sb_data_o = '{addr: dispatch_addr_i, data: dispatch_data_i};

  // new slot starts not written back
  // old mapping rides along so commit can release it
  always_comb
  begin
    issue_entry_o          = '0;
    issue_entry_o.wb       = 1'b0;
    issue_entry_o.w_v      = dispatch_w_v_i;
    issue_entry_o.is_store = dispatch_is_store_i;
    if (dispatch_w_v_i)
    begin
      issue_entry_o.freed_reg = map_q[dispatch_dest_i];
    end
  end

  // map table, identity after reset
  always_ff @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      for (int r = 0; r < `NUM_ARCH_REG; r++)
      begin
        map_q[r] <= phys_reg_t'(r);
      end
    end
    else if (accept && dispatch_w_v_i)
    begin
      map_q[dispatch_dest_i] <= fl_head_i;
    end
  end

endmodule

`default_nettype wire

/* src/rob.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ooo_macros.svh"

module rob (
  input  logic                               clk_i,
  input  logic                               reset_i,

  // writeback ports
  input  ooo_pkg::cdb_t [`NUM_FU-1:0]        cdb_i,

  // allocation from dispatch
  input  logic                               issue_rob_valid_i,
  input  ooo_pkg::rob_entry_t                issue_rob_entry_i,
  output ooo_pkg::rob_idx_t                  rob_issue_entry_num_o,
  output logic                               rob_issue_ready_o,

  // register writer commit, returns the old register
  output logic                               rob_phys_valid_o,
  output ooo_pkg::phys_reg_t                 rob_phys_reg_cl_o,

  // store commit, pops the store buffer
  output logic                               rob_sb_valid_o
);

  import ooo_pkg::*;

  localparam int CNT_W = $clog2(`ROB_ENTRY) + 1;

  rob_entry_t [`ROB_ENTRY-1:0] rob_q;
  rob_entry_t [`ROB_ENTRY-1:0] rob_n;
  rob_idx_t                    alloc_ptr_q;
  rob_idx_t                    alloc_ptr_n;
  rob_idx_t                    commit_ptr_q;
  rob_idx_t                    commit_ptr_n;
  // free slots, not occupied ones
  logic [CNT_W-1:0]            free_cnt_q;
  logic [CNT_W-1:0]            free_cnt_n;
  rob_entry_t                  head;
  logic                        do_alloc;
  logic                        do_commit;

  assign rob_issue_ready_o     = (free_cnt_q != '0);
  assign rob_issue_entry_num_o = alloc_ptr_q;

  assign do_alloc = issue_rob_valid_i && rob_issue_ready_o;

  // retired slots have wb cleared, so an empty head never commits
  assign head      = rob_q[commit_ptr_q];
  assign do_commit = head.wb;

  assign rob_sb_valid_o    = head.wb && head.is_store;
  assign rob_phys_valid_o  = head.wb && head.w_v && !head.is_store;
  assign rob_phys_reg_cl_o = head.freed_reg;

  always_comb
  begin
    rob_n        = rob_q;
    alloc_ptr_n  = alloc_ptr_q;
    commit_ptr_n = commit_ptr_q;
    free_cnt_n   = free_cnt_q;

    // allocate at the tail
    if (do_alloc)
    begin
      rob_n[alloc_ptr_q]    = issue_rob_entry_i;
      rob_n[alloc_ptr_q].wb = 1'b0;
      alloc_ptr_n           = alloc_ptr_q + 1'b1;
    end

    // mark written back slots, in any order
    for (int j = 0; j < `NUM_FU; j++)
    begin
      if (cdb_i[j].valid)
      begin
        rob_n[cdb_i[j].rob_dest].wb = 1'b1;
      end
    end

    // retire the head, one per cycle
    if (do_commit)
    begin
      rob_n[commit_ptr_q].wb = 1'b0;
      commit_ptr_n           = commit_ptr_q + 1'b1;
    end

    // both at once leaves the count unchanged
    case ({do_alloc, do_commit})
      2'b10:   free_cnt_n = free_cnt_q - 1'b1;
      2'b01:   free_cnt_n = free_cnt_q + 1'b1;
      default: free_cnt_n = free_cnt_q;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      for (int i = 0; i < `ROB_ENTRY; i++)
      begin
        rob_q[i].wb <= 1'b0;
      end
      alloc_ptr_q  <= '0;
      commit_ptr_q <= '0;
      free_cnt_q   <= CNT_W'(`ROB_ENTRY);
    end
    else
    begin
      rob_q        <= rob_n;
      alloc_ptr_q  <= alloc_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      free_cnt_q   <= free_cnt_n;
    end
  end

endmodule

`default_nettype wire

/* src/ooo_commit_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ooo_macros.svh"

module ooo_commit_top (
  input  logic                        clk_i,
  input  logic                        reset_i,

  // dispatch
  input  logic                        dispatch_valid_i,
  input  logic                        dispatch_w_v_i,
  input  logic                        dispatch_is_store_i,
  input  ooo_pkg::arch_reg_t          dispatch_dest_i,
  input  logic [`ADDR_W-1:0]          dispatch_addr_i,
  input  logic [`DATA_W-1:0]          dispatch_data_i,
  output logic                        dispatch_ready_o,
  output ooo_pkg::rob_idx_t           dispatch_rob_idx_o,
  output ooo_pkg::phys_reg_t          dispatch_phys_o,

  // writeback
  input  ooo_pkg::cdb_t [`NUM_FU-1:0] cdb_i,

  // commit
  output logic                        commit_valid_o,
  output ooo_pkg::phys_reg_t          commit_freed_reg_o,
  output logic                        store_valid_o,
  output logic [`ADDR_W-1:0]          store_addr_o,
  output logic [`DATA_W-1:0]          store_data_o
);

  import ooo_pkg::*;

  logic       fl_pop;
  logic       fl_empty;
  phys_reg_t  fl_head;
  logic       sb_push;
  logic       sb_full;
  store_t     sb_data;
  store_t     sb_head;
  logic       issue_valid;
  rob_entry_t issue_entry;
  logic       rob_ready;
  logic       rob_phys_valid;
  phys_reg_t  rob_phys_reg;
  logic       rob_sb_valid;

  assign dispatch_phys_o    = fl_head;
  assign commit_valid_o     = rob_phys_valid;
  assign commit_freed_reg_o = rob_phys_reg;
  assign store_valid_o      = rob_sb_valid;
  assign store_addr_o       = sb_head.addr;
  assign store_data_o       = sb_head.data;

  rename_dispatch u_rename_dispatch (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .dispatch_valid_i    (dispatch_valid_i),
    .dispatch_w_v_i      (dispatch_w_v_i),
    .dispatch_is_store_i (dispatch_is_store_i),
    .dispatch_dest_i     (dispatch_dest_i),
    .dispatch_addr_i     (dispatch_addr_i),
    .dispatch_data_i     (dispatch_data_i),
    .dispatch_ready_o    (dispatch_ready_o),
    .fl_head_i           (fl_head),
    .fl_empty_i          (fl_empty),
    .fl_pop_o            (fl_pop),
    .sb_full_i           (sb_full),
    .sb_push_o           (sb_push),
    .sb_data_o           (sb_data),
    .rob_ready_i         (rob_ready),
    .issue_valid_o       (issue_valid),
    .issue_entry_o       (issue_entry)
  );

  rob u_rob (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .cdb_i                 (cdb_i),
    .issue_rob_valid_i     (issue_valid),
    .issue_rob_entry_i     (issue_entry),
    .rob_issue_entry_num_o (dispatch_rob_idx_o),
    .rob_issue_ready_o     (rob_ready),
    .rob_phys_valid_o      (rob_phys_valid),
    .rob_phys_reg_cl_o     (rob_phys_reg),
    .rob_sb_valid_o        (rob_sb_valid)
  );

  // free list holds registers beyond the identity mapping
  sync_fifo #(
    .payload_t    (phys_reg_t),
    .DEPTH        (`NUM_PHYS_REG - `NUM_ARCH_REG),
    .PRELOAD      (1'b1),
    .PRELOAD_BASE (`NUM_ARCH_REG)
  ) u_free_list (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (rob_phys_valid),
    .push_data_i (rob_phys_reg),
    .pop_i       (fl_pop),
    .head_o      (fl_head),
    .empty_o     (fl_empty),
    .full_o      ()
  );

  // store buffer drains in commit order
  sync_fifo #(
    .payload_t (store_t),
    .DEPTH     (`SB_DEPTH)
  ) u_store_buf (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (sb_push),
    .push_data_i (sb_data),
    .pop_i       (rob_sb_valid),
    .head_o      (sb_head),
    .empty_o     (),
    .full_o      (sb_full)
  );

endmodule

`default_nettype wire

/* tb/tb_ooo_commit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ooo_macros.svh"

module tb_ooo_commit;

  import ooo_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int N_RANDOM     = 200;
  localparam int N_DIRECTED   = `ROB_ENTRY + `NUM_PHYS_REG - `NUM_ARCH_REG;
  // worst case of 40 cycles per instruction
  localparam int WATCHDOG_NS  = (N_RANDOM + N_DIRECTED) * 40 * CLK_PERIOD
                                + RESET_CYCLES * CLK_PERIOD;
  localparam int K_NONE   = 0;
  localparam int K_WRITER = 1;
  localparam int K_STORE  = 2;

  logic               clk_i;
  logic               reset_i;
  logic               dispatch_valid_i;
  logic               dispatch_w_v_i;
  logic               dispatch_is_store_i;
  arch_reg_t          dispatch_dest_i;
  logic [`ADDR_W-1:0] dispatch_addr_i;
  logic [`DATA_W-1:0] dispatch_data_i;
  logic               dispatch_ready_o;
  rob_idx_t           dispatch_rob_idx_o;
  phys_reg_t          dispatch_phys_o;
  cdb_t [`NUM_FU-1:0] cdb_i;
  logic               commit_valid_o;
  phys_reg_t          commit_freed_reg_o;
  logic               store_valid_o;
  logic [`ADDR_W-1:0] store_addr_o;
  logic [`DATA_W-1:0] store_data_o;

  // reference model state
  phys_reg_t          model_map [`NUM_ARCH_REG];
  phys_reg_t          fl_q [$];
  rob_idx_t           order_q [$];
  rob_idx_t           tail_idx;
  int                 sb_cnt;
  int                 slot_kind [`ROB_ENTRY];
  logic               slot_wb [`ROB_ENTRY];
  phys_reg_t          slot_freed [`ROB_ENTRY];
  logic [`ADDR_W-1:0] slot_addr [`ROB_ENTRY];
  logic [`DATA_W-1:0] slot_data [`ROB_ENTRY];
  logic               wb_en;
  int                 error_count;
  int                 n_dispatched;
  int                 n_reg_commits;
  int                 n_store_commits;

  ooo_commit_top u_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    error_count++;
    $display("CHECK FAILED t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
  endtask

  task automatic report_problem(input string what);
    error_count++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  // mapped now or waiting to be released by an uncommitted writer
  function automatic logic reg_in_use(input phys_reg_t p);
    logic hit;
    hit = 1'b0;
    for (int r = 0; r < `NUM_ARCH_REG; r++)
    begin
      hit = hit || (model_map[r] == p);
    end
    foreach (order_q[k])
    begin
      hit = hit || (slot_kind[order_q[k]] == K_WRITER && slot_freed[order_q[k]] == p);
    end
    return hit;
  endfunction

  // leaves valid high once accepted so offers can run back to back
  task automatic offer_instr(input int kind);
    @(negedge clk_i);
    dispatch_valid_i    = 1'b1;
    dispatch_w_v_i      = (kind == K_WRITER);
    dispatch_is_store_i = (kind == K_STORE);
    dispatch_dest_i     = arch_reg_t'($urandom());
    dispatch_addr_i     = `ADDR_W'($urandom());
    dispatch_data_i     = $urandom();
    do
    begin
      @(posedge clk_i);
    end
    while (!dispatch_ready_o);
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!dispatch_ready_o && cycles < 100)
    begin
      @(negedge clk_i);
      cycles++;
    end
    assert (dispatch_ready_o)
      else report_problem("dispatch_ready_o did not return after a stall");
  endtask

  task automatic wait_drain();
    while (order_q.size() != 0)
    begin
      @(negedge clk_i);
    end
  endtask

  // reference model stepped at every rising edge
  always @(posedge clk_i)
  begin : model_update
    logic     exp_ready;
    logic     head_wb;
    rob_idx_t head;
    head_wb = 1'b0;
    head    = '0;
    if (reset_i)
    begin
      exp_ready = (order_q.size() < `ROB_ENTRY) && (!dispatch_w_v_i || fl_q.size() > 0)
                  && (!dispatch_is_store_i || sb_cnt < `SB_DEPTH);
      assert (dispatch_ready_o == exp_ready)
        else report_mismatch("dispatch_ready_o", 64'(dispatch_ready_o), 64'(exp_ready));
      if (order_q.size() > 0)
      begin
        head    = order_q[0];
        head_wb = slot_wb[head];
      end
      // only the oldest slot may retire while younger written back slots wait
      assert (commit_valid_o == (head_wb && slot_kind[head] == K_WRITER))
        else report_mismatch("commit_valid_o", 64'(commit_valid_o),
                             64'(head_wb && slot_kind[head] == K_WRITER));
      assert (store_valid_o == (head_wb && slot_kind[head] == K_STORE))
        else report_mismatch("store_valid_o", 64'(store_valid_o),
                             64'(head_wb && slot_kind[head] == K_STORE));
      if (commit_valid_o && head_wb)
      begin
        assert (commit_freed_reg_o == slot_freed[head])
          else report_mismatch("commit_freed_reg_o", 64'(commit_freed_reg_o),
                               64'(slot_freed[head]));
      end
      if (store_valid_o && head_wb)
      begin
        assert (store_addr_o == slot_addr[head])
          else report_mismatch("store_addr_o", 64'(store_addr_o), 64'(slot_addr[head]));
        assert (store_data_o == slot_data[head])
          else report_mismatch("store_data_o", 64'(store_data_o), 64'(slot_data[head]));
      end
      for (int j = 0; j < `NUM_FU; j++)
      begin
        if (cdb_i[j].valid)
        begin
          slot_wb[cdb_i[j].rob_dest] = 1'b1;
        end
      end
      if (dispatch_valid_i && dispatch_ready_o)
      begin
        assert (dispatch_rob_idx_o == tail_idx)
          else report_mismatch("dispatch_rob_idx_o", 64'(dispatch_rob_idx_o), 64'(tail_idx));
        slot_kind[tail_idx] = dispatch_w_v_i ? K_WRITER : (dispatch_is_store_i ? K_STORE : K_NONE);
        slot_wb[tail_idx]   = 1'b0;
        slot_addr[tail_idx] = dispatch_addr_i;
        slot_data[tail_idx] = dispatch_data_i;
        if (dispatch_w_v_i && fl_q.size() > 0)
        begin
          // freed registers come back in the order they were released
          assert (dispatch_phys_o == fl_q[0])
            else report_mismatch("dispatch_phys_o", 64'(dispatch_phys_o), 64'(fl_q[0]));
          assert (!reg_in_use(dispatch_phys_o))
            else report_problem("dispatch_phys_o handed out a register still in use");
          slot_freed[tail_idx]       = model_map[dispatch_dest_i];
          model_map[dispatch_dest_i] = fl_q.pop_front();
        end
        else if (dispatch_is_store_i)
        begin
          sb_cnt++;
        end
        order_q.push_back(tail_idx);
        tail_idx++;
        n_dispatched++;
      end
      if (head_wb)
      begin
        void'(order_q.pop_front());
        if (slot_kind[head] == K_WRITER)
        begin
          fl_q.push_back(slot_freed[head]);
          n_reg_commits++;
        end
        else if (slot_kind[head] == K_STORE)
        begin
          sb_cnt--;
          n_store_commits++;
        end
      end
    end
  end

  // plays the functional units with random slots out of order
  initial
  begin : writeback_driver
    rob_idx_t cand [$];
    int       pick;
    cdb_i = '0;
    forever
    begin
      @(negedge clk_i);
      cdb_i = '0;
      cand.delete();
      foreach (order_q[k])
      begin
        if (!slot_wb[order_q[k]])
        begin
          cand.push_back(order_q[k]);
        end
      end
      for (int j = 0; j < `NUM_FU; j++)
      begin
        if (wb_en && cand.size() > 0 && $urandom_range(1, 0) == 1)
        begin
          pick = int'($urandom_range(cand.size() - 1, 0));
          cdb_i[j].valid    = 1'b1;
          cdb_i[j].rob_dest = cand[pick];
          cand.delete(pick);
        end
      end
    end
  end

  initial
  begin : main_sequence
    void'($urandom(32'he78d_398c));
    error_count     = 0;
    n_dispatched    = 0;
    n_reg_commits   = 0;
    n_store_commits = 0;
    wb_en           = 1'b0;
    sb_cnt          = 0;
    tail_idx        = '0;
    for (int r = 0; r < `NUM_ARCH_REG; r++)
    begin
      model_map[r] = phys_reg_t'(r);
    end
    for (int p = `NUM_ARCH_REG; p < `NUM_PHYS_REG; p++)
    begin
      fl_q.push_back(phys_reg_t'(p));
    end
    for (int i = 0; i < `ROB_ENTRY; i++)
    begin
      slot_wb[i]   = 1'b0;
      slot_kind[i] = K_NONE;
    end
    reset_i             = 1'b0;
    dispatch_valid_i    = 1'b0;
    dispatch_w_v_i      = 1'b0;
    dispatch_is_store_i = 1'b0;
    dispatch_dest_i     = '0;
    dispatch_addr_i     = '0;
    dispatch_data_i     = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b1;
    assert (dispatch_ready_o == 1'b1)
      else report_mismatch("dispatch_ready_o", 64'(dispatch_ready_o), 64'd1);
    assert (!commit_valid_o && !store_valid_o)
      else report_problem("commit strobe raised right after reset");

    // ROB full with nothing written back
    repeat (`ROB_ENTRY) offer_instr(K_NONE);
    @(negedge clk_i);
    assert (!dispatch_ready_o)
      else report_problem("dispatch_ready_o stayed high with a full ROB");
    dispatch_valid_i = 1'b0;
    wb_en            = 1'b1;
    wait_ready();
    wait_drain();

    // free list runs dry before the ROB does
    wb_en = 1'b0;
    repeat (`NUM_PHYS_REG - `NUM_ARCH_REG) offer_instr(K_WRITER);
    @(negedge clk_i);
    assert (!dispatch_ready_o)
      else report_problem("dispatch_ready_o stayed high for a writer with no free register");
    dispatch_valid_i = 1'b0;
    wb_en            = 1'b1;
    wait_ready();
    wait_drain();

    for (int i = 0; i < N_RANDOM; i++)
    begin
      offer_instr(int'($urandom_range(2, 0)));
      if ($urandom_range(3, 0) == 0)
      begin
        @(negedge clk_i);
        dispatch_valid_i = 1'b0;
      end
    end
    @(negedge clk_i);
    dispatch_valid_i = 1'b0;
    wait_drain();
    repeat (2) @(negedge clk_i);

    $display("Summary: %0d errors, %0d dispatched, %0d register commits, %0d store commits",
             error_count, n_dispatched, n_reg_commits, n_store_commits);
    if (error_count == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/ooo_pkg.sv
src/sync_fifo.sv
src/rename_dispatch.sv
src/rob.sv
src/ooo_commit_top.sv
tb/tb_ooo_commit.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f all.f \
  --top-module tb_ooo_commit \
  -Mdir obj_dir \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
